// File: design/isa_pkg.sv
package isa_pkg;

    localparam int xlen       = 32;
    localparam int reg_addr_w = 5;

    // funct7 patterns that separate the base and alternate ALU operations
    localparam logic [6:0] funct7_base = 7'b0000000;
    localparam logic [6:0] funct7_alt  = 7'b0100000;

    // The system class is told apart by the I immediate
    localparam logic [11:0] imm12_ecall  = 12'h000;
    localparam logic [11:0] imm12_ebreak = 12'h001;

    typedef enum logic [6:0] {
        opc_lui    = 7'b0110111,
        opc_auipc  = 7'b0010111,
        opc_jal    = 7'b1101111,
        opc_jalr   = 7'b1100111,
        opc_branch = 7'b1100011,
        opc_load   = 7'b0000011,
        opc_store  = 7'b0100011,
        opc_op_imm = 7'b0010011,
        opc_op     = 7'b0110011,
        opc_system = 7'b1110011
    } opcode_e;

    typedef enum logic [2:0] {
        type_n, type_r, type_i, type_s, type_b, type_u, type_j
    } inst_type_e;

    typedef enum logic [3:0] {
        cls_none, cls_lui, cls_auipc, cls_jal, cls_jalr, cls_branch,
        cls_load, cls_store, cls_op_imm, cls_op, cls_system
    } inst_class_e;

    // One number per supported instruction and inst_inv for anything else
    typedef enum logic [5:0] {
        inst_add, inst_sub, inst_sll, inst_slt, inst_sltu,
        inst_xor, inst_srl, inst_sra, inst_or, inst_and,
        inst_addi, inst_slti, inst_sltiu, inst_xori, inst_ori,
        inst_andi, inst_slli, inst_srli, inst_srai,
        inst_lb, inst_lh, inst_lw, inst_lbu, inst_lhu,
        inst_sb, inst_sh, inst_sw,
        inst_beq, inst_bne, inst_blt, inst_bge, inst_bltu, inst_bgeu,
        inst_lui, inst_auipc, inst_jal, inst_jalr,
        inst_ecall, inst_ebreak,
        inst_inv
    } inst_num_e;

endpackage

// File: design/decode_pkg.sv
package decode_pkg;

    // Instruction word with the pc it was fetched from
    typedef struct packed {
        logic [isa_pkg::xlen-1:0] inst;
        logic [isa_pkg::xlen-1:0] pc;
    } fetch_pkt_t;

    // Fully decoded instruction with its source operands
    typedef struct packed {
        logic [isa_pkg::xlen-1:0]       pc;
        isa_pkg::inst_num_e             inst_num;
        isa_pkg::inst_type_e            inst_type;
        logic [isa_pkg::reg_addr_w-1:0] rd;
        logic [isa_pkg::reg_addr_w-1:0] rs1;
        logic [isa_pkg::reg_addr_w-1:0] rs2;
        logic [isa_pkg::xlen-1:0]       imm;
        logic [isa_pkg::xlen-1:0]       rs1_val;
        logic [isa_pkg::xlen-1:0]       rs2_val;
    } dec_pkt_t;

    // Register file write from a later stage
    typedef struct packed {
        logic                           en;
        logic [isa_pkg::reg_addr_w-1:0] addr;
        logic [isa_pkg::xlen-1:0]       data;
    } reg_wr_t;

endpackage

// File: design/fetch_buffer.sv
module fetch_buffer (
    input  logic                   clk,
    input  logic                   rst_n,
    input  decode_pkg::fetch_pkt_t in_pkt,
    input  logic                   in_valid,
    output logic                   in_ready,
    output decode_pkg::fetch_pkt_t buf_pkt,
    output logic                   buf_valid,
    input  logic                   buf_ready
);
    import decode_pkg::*;

    typedef enum logic [1:0] {
        st_empty, st_main, st_full
    } occ_e;

    occ_e       state;
    fetch_pkt_t main_q;
    fetch_pkt_t spare_q;
    logic       push;
    logic       pop;

    // Ready comes from occupancy alone, so no combinational path to buf_ready
    assign in_ready  = (state != st_full);
    assign buf_valid = (state != st_empty);
    assign buf_pkt   = main_q;

    assign push = in_valid && in_ready;
    assign pop  = buf_valid && buf_ready;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state <= st_empty;
        end else begin
            case (state)
                st_empty: if (push) state <= st_main;
                st_main: begin
                    if (push && !pop) state <= st_full;
                    else if (!push && pop) state <= st_empty;
                end
                st_full: if (pop) state <= st_main;
                default: state <= st_empty;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == st_full) begin
            if (pop) main_q <= spare_q;
        end else if (push) begin
            // With the main entry staying put the new word goes to the spare
            if (state == st_main && !pop) spare_q <= in_pkt;
            else main_q <= in_pkt;
        end
    end

endmodule

// File: design/opcode_decode.sv
module opcode_decode (
    input  logic [31:0]          inst,
    output isa_pkg::inst_class_e inst_class,
    output isa_pkg::inst_type_e  inst_type,
    output logic [4:0]           rd,
    output logic [4:0]           rs1,
    output logic [4:0]           rs2,
    output logic [31:0]          imm
);
    import isa_pkg::*;

    assign rd  = inst[11:7];
    assign rs1 = inst[19:15];
    assign rs2 = inst[24:20];

    always_comb begin
        case (inst[6:0])
            opc_lui: begin
                inst_class = cls_lui;
                inst_type  = type_u;
            end
            opc_auipc: begin
                inst_class = cls_auipc;
                inst_type  = type_u;
            end
            opc_jal: begin
                inst_class = cls_jal;
                inst_type  = type_j;
            end
            opc_jalr: begin
                inst_class = cls_jalr;
                inst_type  = type_i;
            end
            opc_branch: begin
                inst_class = cls_branch;
                inst_type  = type_b;
            end
            opc_load: begin
                inst_class = cls_load;
                inst_type  = type_i;
            end
            opc_store: begin
                inst_class = cls_store;
                inst_type  = type_s;
            end
            opc_op_imm: begin
                inst_class = cls_op_imm;
                inst_type  = type_i;
            end
            opc_op: begin
                inst_class = cls_op;
                inst_type  = type_r;
            end
            opc_system: begin
                inst_class = cls_system;
                inst_type  = type_i;
            end
            default: begin
                inst_class = cls_none;
                inst_type  = type_n;
            end
        endcase
    end

    // The sign bit is always inst[31] and the formats only scatter the rest
    always_comb begin
        case (inst_type)
            type_i:  imm = {{20{inst[31]}}, inst[31:20]};
            type_s:  imm = {{20{inst[31]}}, inst[31:25], inst[11:7]};
            type_b:  imm = {{20{inst[31]}}, inst[7], inst[30:25], inst[11:8], 1'b0};
            type_u:  imm = {inst[31:12], 12'b0};
            type_j:  imm = {{12{inst[31]}}, inst[19:12], inst[20], inst[30:21], 1'b0};
            default: imm = '0;
        endcase
    end

endmodule

// File: design/funct_decode.sv
module funct_decode (
    input  isa_pkg::inst_class_e inst_class,
    input  logic [2:0]           funct3,
    input  logic [6:0]           funct7,
    input  logic [11:0]          imm12,
    output isa_pkg::inst_num_e   inst_num
);
    import isa_pkg::*;

    always_comb begin
        inst_num = inst_inv;
        case (inst_class)
            cls_lui:   inst_num = inst_lui;
            cls_auipc: inst_num = inst_auipc;
            cls_jal:   inst_num = inst_jal;
            cls_jalr:  if (funct3 == 3'b000) inst_num = inst_jalr;
            cls_branch: begin
                case (funct3)
                    3'b000:  inst_num = inst_beq;
                    3'b001:  inst_num = inst_bne;
                    3'b100:  inst_num = inst_blt;
                    3'b101:  inst_num = inst_bge;
                    3'b110:  inst_num = inst_bltu;
                    3'b111:  inst_num = inst_bgeu;
                    default: inst_num = inst_inv;
                endcase
            end
            cls_load: begin
                case (funct3)
                    3'b000:  inst_num = inst_lb;
                    3'b001:  inst_num = inst_lh;
                    3'b010:  inst_num = inst_lw;
                    3'b100:  inst_num = inst_lbu;
                    3'b101:  inst_num = inst_lhu;
                    default: inst_num = inst_inv;
                endcase
            end
            cls_store: begin
                case (funct3)
                    3'b000:  inst_num = inst_sb;
                    3'b001:  inst_num = inst_sh;
                    3'b010:  inst_num = inst_sw;
                    default: inst_num = inst_inv;
                endcase
            end
            cls_op_imm: begin
                case (funct3)
                    3'b000: inst_num = inst_addi;
                    3'b010: inst_num = inst_slti;
                    3'b011: inst_num = inst_sltiu;
                    3'b100: inst_num = inst_xori;
                    3'b110: inst_num = inst_ori;
                    3'b111: inst_num = inst_andi;
                    // Shift amounts use the low five immediate bits only
                    3'b001: if (funct7 == funct7_base) inst_num = inst_slli;
                    3'b101: begin
                        if (funct7 == funct7_base) inst_num = inst_srli;
                        else if (funct7 == funct7_alt) inst_num = inst_srai;
                    end
                    default: inst_num = inst_inv;
                endcase
            end
            cls_op: begin
                if (funct7 == funct7_base) begin
                    case (funct3)
                        3'b000:  inst_num = inst_add;
                        3'b001:  inst_num = inst_sll;
                        3'b010:  inst_num = inst_slt;
                        3'b011:  inst_num = inst_sltu;
                        3'b100:  inst_num = inst_xor;
                        3'b101:  inst_num = inst_srl;
                        3'b110:  inst_num = inst_or;
                        default: inst_num = inst_and;
                    endcase
                end else if (funct7 == funct7_alt) begin
                    if (funct3 == 3'b000) inst_num = inst_sub;
                    else if (funct3 == 3'b101) inst_num = inst_sra;
                end
            end
            cls_system: begin
                if (funct3 == 3'b000 && imm12 == imm12_ecall) inst_num = inst_ecall;
                else if (funct3 == 3'b000 && imm12 == imm12_ebreak) inst_num = inst_ebreak;
            end
            default: inst_num = inst_inv;
        endcase
    end

endmodule

// File: design/operand_read.sv
module operand_read (
    input  logic                 clk,
    input  logic                 rst_n,
    input  decode_pkg::dec_pkt_t pkt_in,
    input  logic                 in_valid,
    output logic                 in_ready,
    input  decode_pkg::reg_wr_t  wr,
    output decode_pkg::dec_pkt_t out_pkt,
    output logic                 out_valid,
    input  logic                 out_ready
);
    import isa_pkg::*;
    import decode_pkg::*;

    logic [xlen-1:0] regs [1:31];
    dec_pkt_t        next_pkt;
    logic            xfer;

    // Register 0 is hardwired, and a same-edge write wins over the stored value
    function automatic logic [xlen-1:0] read_port(input logic [reg_addr_w-1:0] addr);
        logic [xlen-1:0] val;
        val = '0;
        if (addr != '0) begin
            if (wr.en && wr.addr == addr) val = wr.data;
            else val = regs[addr];
        end
        return val;
    endfunction

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int r = 1; r < 32; r++) begin
                regs[r] <= '0;
            end
        end else if (wr.en && wr.addr != '0) begin
            regs[wr.addr] <= wr.data;
        end
    end

    assign in_ready = !out_valid || out_ready;
    assign xfer     = in_valid && in_ready;

    always_comb begin
        next_pkt         = pkt_in;
        next_pkt.rs1_val = read_port(pkt_in.rs1);
        next_pkt.rs2_val = read_port(pkt_in.rs2);
        // Bad funct fields on a legal opcode still leave as format n
        if (pkt_in.inst_num == inst_inv) begin
            next_pkt.inst_type = type_n;
            next_pkt.imm       = '0;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            out_valid <= 1'b0;
        end else if (xfer) begin
            out_valid <= 1'b1;
        end else if (out_ready) begin
            out_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (xfer) out_pkt <= next_pkt;
    end

endmodule

// File: design/decode_top.sv
module decode_top (
    input  logic                   clk,
    input  logic                   rst_n,
    input  decode_pkg::fetch_pkt_t in_pkt,
    input  logic                   in_valid,
    output logic                   in_ready,
    input  decode_pkg::reg_wr_t    wr,
    output decode_pkg::dec_pkt_t   out_pkt,
    output logic                   out_valid,
    input  logic                   out_ready
);
    import isa_pkg::*;
    import decode_pkg::*;

    fetch_pkt_t             buf_pkt;
    logic                   buf_valid;
    logic                   buf_ready;
    inst_class_e            inst_class;
    inst_type_e             inst_type;
    inst_num_e              inst_num;
    logic [reg_addr_w-1:0]  rd;
    logic [reg_addr_w-1:0]  rs1;
    logic [reg_addr_w-1:0]  rs2;
    logic [xlen-1:0]        imm;
    dec_pkt_t               dec_pkt;

    fetch_buffer i_fetch_buffer (
        .clk      (clk),
        .rst_n    (rst_n),
        .in_pkt   (in_pkt),
        .in_valid (in_valid),
        .in_ready (in_ready),
        .buf_pkt  (buf_pkt),
        .buf_valid(buf_valid),
        .buf_ready(buf_ready)
    );

    opcode_decode i_opcode_decode (
        .inst      (buf_pkt.inst),
        .inst_class(inst_class),
        .inst_type (inst_type),
        .rd        (rd),
        .rs1       (rs1),
        .rs2       (rs2),
        .imm       (imm)
    );

    funct_decode i_funct_decode (
        .inst_class(inst_class),
        .funct3    (buf_pkt.inst[14:12]),
        .funct7    (buf_pkt.inst[31:25]),
        .imm12     (buf_pkt.inst[31:20]),
        .inst_num  (inst_num)
    );

    // Operand values are filled in by operand_read
    assign dec_pkt = '{pc: buf_pkt.pc, inst_num: inst_num, inst_type: inst_type,
                       rd: rd, rs1: rs1, rs2: rs2, imm: imm,
                       rs1_val: '0, rs2_val: '0};

    operand_read i_operand_read (
        .clk      (clk),
        .rst_n    (rst_n),
        .pkt_in   (dec_pkt),
        .in_valid (buf_valid),
        .in_ready (buf_ready),
        .wr       (wr),
        .out_pkt  (out_pkt),
        .out_valid(out_valid),
        .out_ready(out_ready)
    );

endmodule

// File: verif/decode_props.sv
module decode_props (
    input logic                   clk,
    input logic                   rst_n,
    input decode_pkg::fetch_pkt_t in_pkt,
    input logic                   in_valid,
    input logic                   in_ready,
    input decode_pkg::dec_pkt_t   out_pkt,
    input logic                   out_valid,
    input logic                   out_ready
);
    timeunit 1ns;
    timeprecision 100ps;

    // A stalled output keeps its packet until the consumer takes it
    out_hold: assert property (@(posedge clk) disable iff (!rst_n)
        out_valid && !out_ready |=> out_valid && $stable(out_pkt))
        else $error("out_pkt changed or out_valid dropped while stalled");

    in_hold: assert property (@(posedge clk) disable iff (!rst_n)
        in_valid && !in_ready |=> in_valid && $stable(in_pkt))
        else $error("in_pkt changed or in_valid dropped before its transfer");

    reset_state: assert property (@(posedge clk)
        !rst_n |=> !out_valid && in_ready)
        else $error("out_valid or in_ready wrong right after reset");

endmodule

bind decode_top decode_props i_decode_props (
    .clk      (clk),
    .rst_n    (rst_n),
    .in_pkt   (in_pkt),
    .in_valid (in_valid),
    .in_ready (in_ready),
    .out_pkt  (out_pkt),
    .out_valid(out_valid),
    .out_ready(out_ready)
);

// File: verif/decode_tb.sv
module decode_tb;
    timeunit 1ns;
    timeprecision 100ps;
    import isa_pkg::*;
    import decode_pkg::*;

    localparam int clk_period    = 4;
    localparam int num_writes    = 32;
    localparam int num_insts     = 800;
    localparam int cycles_per_op = 20;

    logic       clk = 1'b0;
    logic       rst_n;
    fetch_pkt_t in_pkt;
    logic       in_valid;
    logic       in_ready;
    reg_wr_t    wr;
    dec_pkt_t   out_pkt;
    logic       out_valid;
    logic       out_ready;

    logic [31:0] lfsr;
    logic [31:0] model_regs [32] = '{default: 32'h0};
    dec_pkt_t    expected_q [$];
    int          received = 0;

    // Instruction numbers indexed by funct3
    inst_num_e branch_num [8] = '{inst_beq, inst_bne, inst_inv, inst_inv,
                                  inst_blt, inst_bge, inst_bltu, inst_bgeu};
    inst_num_e load_num [8]   = '{inst_lb, inst_lh, inst_lw, inst_inv,
                                  inst_lbu, inst_lhu, inst_inv, inst_inv};
    inst_num_e store_num [8]  = '{inst_sb, inst_sh, inst_sw, inst_inv,
                                  inst_inv, inst_inv, inst_inv, inst_inv};
    inst_num_e imm_num [8]    = '{inst_addi, inst_slli, inst_slti, inst_sltiu,
                                  inst_xori, inst_srli, inst_ori, inst_andi};
    inst_num_e op_num [8]     = '{inst_add, inst_sll, inst_slt, inst_sltu,
                                  inst_xor, inst_srl, inst_or, inst_and};

    always #(clk_period / 2) clk = ~clk;

    decode_top i_dut (
        .clk      (clk),
        .rst_n    (rst_n),
        .in_pkt   (in_pkt),
        .in_valid (in_valid),
        .in_ready (in_ready),
        .wr       (wr),
        .out_pkt  (out_pkt),
        .out_valid(out_valid),
        .out_ready(out_ready)
    );

    // Galois LFSR on the maximal length polynomial x^32+x^22+x^2+x+1
    function automatic logic next_bit();
        logic out;
        out  = lfsr[0];
        lfsr = lfsr >> 1;
        if (out) lfsr = lfsr ^ 32'h8020_0003;
        return out;
    endfunction

    function automatic logic [31:0] random_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) v = {v[30:0], next_bit()};
        return v;
    endfunction

    // Mostly legal encodings with a random word now and then
    function automatic logic [31:0] random_inst();
        logic [31:0] w;
        logic [3:0]  pick;
        w    = random_bits(32);
        pick = 4'(random_bits(4));
        case (pick)
            4'd0:    w[6:0] = opc_lui;
            4'd1:    w[6:0] = opc_auipc;
            4'd2:    w[6:0] = opc_jal;
            4'd3:    w[6:0] = opc_jalr;
            4'd4:    w[6:0] = opc_branch;
            4'd5:    w[6:0] = opc_load;
            4'd6:    w[6:0] = opc_store;
            4'd7:    w[6:0] = opc_op_imm;
            4'd8:    w[6:0] = opc_op;
            4'd9:    w[6:0] = opc_system;
            default: w[6:0] = w[6:0];
        endcase
        // One in eight keeps its random funct fields
        if (random_bits(3) != 32'd0) begin
            if (w[6:0] == opc_op || (w[6:0] == opc_op_imm && w[13:12] == 2'b01))
                w[31:25] = (random_bits(1) != 32'd0) ? 7'h20 : 7'h00;
            if (w[6:0] == opc_jalr || w[6:0] == opc_system) w[14:12] = 3'b000;
            if (w[6:0] == opc_system) w[31:20] = {11'h000, w[20]};
        end
        return w;
    endfunction

    function automatic dec_pkt_t predict(input fetch_pkt_t f);
        dec_pkt_t    p;
        logic [31:0] w;
        logic [2:0]  f3;
        logic [6:0]  f7;
        w  = f.inst;
        f3 = w[14:12];
        f7 = w[31:25];
        p  = '0;
        p.pc        = f.pc;
        p.rd        = w[11:7];
        p.rs1       = w[19:15];
        p.rs2       = w[24:20];
        p.inst_num  = inst_inv;
        p.inst_type = type_i;
        case (w[6:0])
            opc_lui:    {p.inst_type, p.inst_num} = {type_u, inst_lui};
            opc_auipc:  {p.inst_type, p.inst_num} = {type_u, inst_auipc};
            opc_jal:    {p.inst_type, p.inst_num} = {type_j, inst_jal};
            opc_jalr:   p.inst_num = (f3 == 3'd0) ? inst_jalr : inst_inv;
            opc_branch: {p.inst_type, p.inst_num} = {type_b, branch_num[f3]};
            opc_load:   p.inst_num = load_num[f3];
            opc_store:  {p.inst_type, p.inst_num} = {type_s, store_num[f3]};
            opc_op_imm: begin
                p.inst_num = imm_num[f3];
                if (f3 == 3'd1 && f7 != 7'h00) p.inst_num = inst_inv;
                if (f3 == 3'd5 && f7 == 7'h20) p.inst_num = inst_srai;
                else if (f3 == 3'd5 && f7 != 7'h00) p.inst_num = inst_inv;
            end
            opc_op: begin
                p.inst_type = type_r;
                if (f7 == 7'h00) p.inst_num = op_num[f3];
                else if (f7 == 7'h20 && f3 == 3'd0) p.inst_num = inst_sub;
                else if (f7 == 7'h20 && f3 == 3'd5) p.inst_num = inst_sra;
            end
            opc_system: begin
                if (f3 == 3'd0 && w[31:20] == 12'h000) p.inst_num = inst_ecall;
                if (f3 == 3'd0 && w[31:20] == 12'h001) p.inst_num = inst_ebreak;
            end
            default:    p.inst_num = inst_inv;
        endcase
        if (p.inst_num == inst_inv) p.inst_type = type_n;
        case (p.inst_type)
            type_i:  p.imm = 32'($signed(w[31:20]));
            type_s:  p.imm = 32'($signed({w[31:25], w[11:7]}));
            type_b:  p.imm = 32'($signed({w[31], w[7], w[30:25], w[11:8], 1'b0}));
            type_u:  p.imm = {w[31:12], 12'h000};
            type_j:  p.imm = 32'($signed({w[31], w[19:12], w[20], w[30:21], 1'b0}));
            default: p.imm = 32'h0;
        endcase
        p.rs1_val = model_regs[p.rs1];
        p.rs2_val = model_regs[p.rs2];
        return p;
    endfunction

    task automatic check_field(input string what, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            $display("error at %0t ns: %s is %h, expected %h", $time, what, got, exp);
            $display("Test failed");
            $fatal(1, "stopping at the first mismatch");
        end
    endtask

    task automatic compare_pkt(input dec_pkt_t got);
        dec_pkt_t exp;
        if (expected_q.size() == 0) begin
            $display("A packet left the stage at %0t ns with none outstanding", $time);
            $display("Test failed");
            $fatal(1, "unexpected output packet");
        end else begin
            exp = expected_q.pop_front();
            check_field("pc", got.pc, exp.pc);
            check_field("inst_num", 32'(got.inst_num), 32'(exp.inst_num));
            check_field("inst_type", 32'(got.inst_type), 32'(exp.inst_type));
            check_field("rd", 32'(got.rd), 32'(exp.rd));
            check_field("rs1", 32'(got.rs1), 32'(exp.rs1));
            check_field("rs2", 32'(got.rs2), 32'(exp.rs2));
            check_field("imm", got.imm, exp.imm);
            check_field("rs1_val", got.rs1_val, exp.rs1_val);
            check_field("rs2_val", got.rs2_val, exp.rs2_val);
            received++;
        end
    endtask

    // Scoreboard sees both handshakes as they stood just before the edge
    always @(posedge clk) begin
        if (rst_n) begin
            if (in_valid && in_ready) expected_q.push_back(predict(in_pkt));
            if (out_valid && out_ready) compare_pkt(out_pkt);
        end
    end

    initial begin
        #((num_writes + num_insts) * cycles_per_op * clk_period);
        $display("Watchdog expired with %0d of %0d packets out", received, num_insts);
        $display("Test failed");
        $fatal(1, "watchdog timeout");
    end

    initial begin
        logic [31:0] wdata;
        int          issued;
        logic        pending;
        lfsr      = 32'd98402;
        rst_n     = 1'b0;
        in_pkt    = '0;
        in_valid  = 1'b0;
        wr        = '0;
        out_ready = 1'b0;
        repeat (2) @(posedge clk);
        #1;
        rst_n = 1'b1;
        check_field("out_valid after reset", 32'(out_valid), 32'd0);
        check_field("in_ready after reset", 32'(in_ready), 32'd1);

        // Register 0 is written too and must still read zero
        for (int a = 0; a < num_writes; a++) begin
            wdata = random_bits(32);
            wr    = '{en: 1'b1, addr: 5'(a), data: wdata};
            if (a != 0) model_regs[5'(a)] = wdata;
            @(posedge clk);
            #1;
        end
        wr = '0;

        issued  = 0;
        pending = 1'b0;
        while (received < num_insts) begin
            @(posedge clk);
            if (in_valid && in_ready) pending = 1'b0;
            #1;
            if (!pending && issued < num_insts && random_bits(2) != 32'd0) begin
                in_pkt.inst = random_inst();
                in_pkt.pc   = 32'h0000_1000 + 32'(issued) * 32'd4;
                pending     = 1'b1;
                issued++;
            end
            in_valid  = pending;
            out_ready = random_bits(1) != 32'd0;
        end

        // With the output always taken any stray packet reaches the scoreboard
        in_valid  = 1'b0;
        out_ready = 1'b1;
        repeat (4) @(posedge clk);
        #1;
        if (out_valid !== 1'b0 || in_ready !== 1'b1) begin
            $display("The stage did not go idle after the last packet left");
            $display("Test failed");
            $fatal(1, "stage not idle");
        end else begin
            $display("Test completed successfully");
            $finish;
        end
    end

endmodule

// File: flist.f
design/isa_pkg.sv
design/decode_pkg.sv
design/fetch_buffer.sv
design/opcode_decode.sv
design/funct_decode.sv
design/operand_read.sv
design/decode_top.sv
verif/decode_props.sv
verif/decode_tb.sv

// File: run.sh
#!/bin/sh
# Build the decode stage testbench with Verilator, run it and judge the log
cd "$(dirname "$0")" || exit 1

log=sim.log

verilator --binary --timing --assert --top-module decode_tb \
    -f flist.f --Mdir obj_dir -o decode_sim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/decode_sim > "$log" 2>&1
status=$?
cat "$log"

if grep -q "Test failed" "$log"; then
    echo "Simulation FAILED"
    exit 1
fi
if [ "$status" -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi
echo "Simulation passed"
exit 0
